/* flist.f */
+incdir+source
source/trace_arch_pkg.sv
source/trace_mon_pkg.sv
source/retire_tracker.sv
source/class_counter.sv
source/csr_snapshot.sv
source/trace_readout.sv
source/trace_monitor_top.sv
testbench/tb_trace_monitor.sv

/* testbench/tb_trace_monitor.sv */
//--------------------------------------------------------------------
// Testbench for the trace monitor: core-side stimulus, Wishbone
// reads, reference model and checks
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "trace_params.svh"

module tb_trace_monitor;
    import trace_arch_pkg::*;
    import trace_mon_pkg::*;

    localparam int n_writes       = 40;
    localparam int n_events       = 60;
    localparam int n_csr_chg      = 6;
    localparam int csr_hold       = 4;
    localparam int n_reads        = 130;
    localparam int test_cycles    = 8 + n_writes + n_events + n_csr_chg * csr_hold
                                    + 3 * n_reads + 20;
    localparam int timeout_cycles = 2 * test_cycles;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        update_pc_en, mprf_wr_en, mstatus_mie_up;
    logic [31:0] update_pc, mprf_wr_data, mtval;
    logic [4:0]  mprf_wr_addr;
    instr_class_e instr_sort;
    logic        mstatus_mie, mstatus_mpie, mtvec_mode, mcause_i;
    logic        mie_msie, mie_mtie, mie_meie, mip_msip, mip_mtip, mip_meip;
    logic [31:6] mtvec_base;
    logic [31:1] mepc;
    exc_code_e   mcause_ec;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [6:0]  wb_adr;
    logic [31:0] wb_dat_o;

    // Reference model
    logic [31:0] shadow_m [0:31];
    int unsigned class_m [0:10];
    logic [31:0] pc_m, wdata_m;
    logic [4:0]  waddr_m;

    logic [31:0] lfsr_q = 32'd92313;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        req_q  = 1'b0;

    trace_monitor_top DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);   // One step per bit
        end
    endtask

    // Expected CSR word from the driven fields
    function automatic logic [31:0] csr_expect(input int idx);
        logic [31:0] w;
        w = '0;
        case (idx)
            0: begin
                w[3]     = mstatus_mie;
                w[7]     = mstatus_mpie;
                w[12:11] = 2'b11;
            end
            1: w = {mtvec_base, 5'b00000, mtvec_mode};
            2: begin
                w[3]  = mie_msie;
                w[7]  = mie_mtie;
                w[11] = mie_meie;
            end
            3: begin
                w[3]  = mip_msip;
                w[7]  = mip_mtip;
                w[11] = mip_meip;
            end
            4: w = {mepc, 1'b0};
            5: begin
                w[31]  = mcause_i;
                w[3:0] = mcause_ec;
            end
            default: w = mtval;
        endcase
        return w;
    endfunction

    //----------------------------------------------------------------
    // Core-side drivers
    //----------------------------------------------------------------
    task automatic core_cycle(input logic pc_en, input logic [31:0] pc,
                              input logic wr_en, input logic [4:0] addr,
                              input logic [31:0] data, input logic ie_up,
                              input logic [3:0] cls);
        int slot;
        @(negedge clk);
        update_pc_en   = pc_en;
        update_pc      = pc;
        mprf_wr_en     = wr_en;
        mprf_wr_addr   = addr;
        mprf_wr_data   = data;
        mstatus_mie_up = ie_up;
        instr_sort     = instr_class_e'(cls);
        if (pc_en || (wr_en && !ie_up)) begin
            slot = (cls > 4'd10) ? 10 : int'(cls);   // Reserved codes count as OTHER
            class_m[slot]++;
            pc_m = pc;
        end
        if (wr_en && addr != 5'd0) begin
            shadow_m[addr] = data;
            waddr_m        = addr;
            wdata_m        = data;
        end
    endtask

    task automatic idle_cycles(input int n);
        @(negedge clk);
        update_pc_en   = 1'b0;
        mprf_wr_en     = 1'b0;
        mstatus_mie_up = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic new_csr_fields();
        logic [31:0] r;
        @(negedge clk);
        rand_bits(10, r);
        {mstatus_mie, mstatus_mpie, mtvec_mode, mcause_i} = r[3:0];
        {mie_msie, mie_mtie, mie_meie, mip_msip, mip_mtip, mip_meip} = r[9:4];
        rand_bits(26, r);
        mtvec_base = r[25:0];
        rand_bits(31, r);
        mepc = r[30:0];
        rand_bits(4, r);
        mcause_ec = exc_code_e'(r[3:0]);
        rand_bits(32, r);
        mtval = (r == mtval) ? ~r : r;   // Always a real change
    endtask

    //----------------------------------------------------------------
    // Wishbone master
    //----------------------------------------------------------------
    task automatic read_word(input logic [6:0] adr, input logic [31:0] exp,
                             input string name);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        checks++;
        assert (wb_dat_o == exp)
        else begin
            errors++;
            $display("** Error: wb_dat_o at %s (adr 0x%02h): expected 0x%08h, actual 0x%08h",
                     name, adr, exp, wb_dat_o);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic write_word(input logic [6:0] adr);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_classes();
        for (int c = 0; c < 11; c++)
            read_word(`TRACE_MAP_CLASS + c, class_m[c], $sformatf("class %0d", c));
    endtask

    // Ack only in the cycle after a sampled request
    always @(posedge clk) req_q <= wb_cyc & wb_stb;

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!wb_ack || req_q)
            else begin
                errors++;
                $display("wb_ack went high with no Wishbone request pending");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Timeout: test sequence did not finish in %0d cycles", timeout_cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    //----------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------
    initial begin
        logic [31:0] ra, rd, rp, rc;
        rst_n = 1'b0;
        update_pc_en = 1'b0;
        update_pc = '0;
        mprf_wr_en = 1'b0;
        mprf_wr_addr = '0;
        mprf_wr_data = '0;
        mstatus_mie_up = 1'b0;
        instr_sort = RVI_CAL;
        {mstatus_mie, mstatus_mpie, mtvec_mode, mcause_i} = '0;
        {mie_msie, mie_mtie, mie_meie, mip_msip, mip_mtip, mip_meip} = '0;
        mtvec_base = '0;
        mepc = '0;
        mcause_ec = exc_code_e'(4'd0);
        mtval = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        for (int i = 0; i < 32; i++)
            shadow_m[i] = '0;
        for (int c = 0; c < 11; c++)
            class_m[c] = 0;
        pc_m = '0;
        waddr_m = '0;
        wdata_m = '0;

        new_csr_fields();   // Settles during reset, no change counted
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Everything reads zero after reset
        read_classes();
        read_word(`TRACE_MAP_CHG, 32'd0, "chg_count");
        read_word(`TRACE_MAP_PC, 32'd0, "last_pc");
        read_word(`TRACE_MAP_WADDR, 32'd0, "last_waddr");
        read_word(`TRACE_MAP_WDATA, 32'd0, "last_wdata");
        for (int i = 0; i < 32; i++)
            read_word(`TRACE_MAP_SHADOW + i, 32'd0, $sformatf("shadow x%0d", i));

        // Random register writes, some to x0 and the last one too
        for (int i = 0; i < n_writes; i++) begin
            rand_bits(5, ra);
            if (i % 10 == 3 || i == n_writes - 1)
                ra = '0;
            rand_bits(32, rd);
            rand_bits(32, rp);
            core_cycle(1'b0, rp, 1'b1, ra[4:0], rd, 1'b0, 4'd0);
        end
        idle_cycles(2);
        for (int i = 0; i < 32; i++)
            read_word(`TRACE_MAP_SHADOW + i, shadow_m[i], $sformatf("shadow x%0d", i));
        read_word(`TRACE_MAP_WADDR, {27'd0, waddr_m}, "last_waddr");
        read_word(`TRACE_MAP_WDATA, wdata_m, "last_wdata");

        // PC retirements with random classes
        for (int i = 0; i < n_events; i++) begin
            rand_bits(4, rc);
            if (i < 5)
                rc = 11 + i;
            rand_bits(32, rp);
            core_cycle(1'b1, rp, 1'b0, 5'd0, 32'd0, 1'b0, rc[3:0]);
        end
        idle_cycles(2);
        read_classes();

        // IE update write, shadow only
        rand_bits(32, rd);
        rand_bits(32, rp);
        core_cycle(1'b0, rp, 1'b1, 5'd7, rd, 1'b1, 4'd2);
        idle_cycles(2);
        read_word(`TRACE_MAP_SHADOW + 7, shadow_m[7], "shadow x7");
        read_word(`TRACE_MAP_WADDR, {27'd0, waddr_m}, "last_waddr");
        read_word(`TRACE_MAP_WDATA, wdata_m, "last_wdata");
        read_word(`TRACE_MAP_PC, pc_m, "last_pc");
        read_classes();

        // CSR changes
        repeat (n_csr_chg) begin
            new_csr_fields();
            repeat (csr_hold - 1) @(negedge clk);
        end
        read_word(`TRACE_MAP_CHG, n_csr_chg, "chg_count");
        for (int i = 0; i < 7; i++)
            read_word(`TRACE_MAP_CSR + i, csr_expect(i), $sformatf("csr word %0d", i));

        // Writes are ignored, unmapped reads give zero
        write_word(`TRACE_MAP_SHADOW + 5);
        write_word(`TRACE_MAP_PC);
        write_word(`TRACE_MAP_CLASS);
        read_word(`TRACE_MAP_SHADOW + 5, shadow_m[5], "shadow x5");
        read_word(`TRACE_MAP_PC, pc_m, "last_pc");
        read_word(`TRACE_MAP_CLASS, class_m[0], "class 0");
        read_word(`TRACE_MAP_CHG, n_csr_chg, "chg_count");
        read_word(7'h2F, 32'd0, "unmapped 0x2F");
        read_word(7'h3B, 32'd0, "unmapped 0x3B");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* source/trace_monitor_top.sv */
//--------------------------------------------------------------------
// Retirement trace monitor top level
// Retire tracking, class counters, CSR snapshot and Wishbone readout
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_monitor_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // Core retire and register write
    input  logic                         update_pc_en,
    input  logic [`TRACE_XLEN-1:0]       update_pc,
    input  logic                         mprf_wr_en,
    input  logic [`TRACE_REG_AW-1:0]     mprf_wr_addr,
    input  logic [`TRACE_XLEN-1:0]       mprf_wr_data,
    input  logic                         mstatus_mie_up,
    input  trace_mon_pkg::instr_class_e  instr_sort,
    // CSR fields
    input  logic                         mstatus_mie,
    input  logic                         mstatus_mpie,
    input  logic [`TRACE_XLEN-1:6]       mtvec_base,
    input  logic                         mtvec_mode,
    input  logic                         mie_msie,
    input  logic                         mie_mtie,
    input  logic                         mie_meie,
    input  logic                         mip_msip,
    input  logic                         mip_mtip,
    input  logic                         mip_meip,
    input  logic [`TRACE_XLEN-1:1]       mepc,
    input  logic                         mcause_i,
    input  trace_arch_pkg::exc_code_e    mcause_ec,
    input  logic [`TRACE_XLEN-1:0]       mtval,
    // Wishbone
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`TRACE_WB_AW-1:0]      wb_adr,
    output logic                         wb_ack,
    output logic [`TRACE_XLEN-1:0]       wb_dat_o
);
    import trace_arch_pkg::*;

    logic [`TRACE_NCLASS-1:0]             class_strb;
    logic [`TRACE_NCLASS*`TRACE_CNT_W-1:0] class_count;
    logic [`TRACE_XLEN-1:0]               last_pc;
    logic [`TRACE_REG_AW-1:0]             last_waddr;
    logic [`TRACE_XLEN-1:0]               last_wdata;
    logic [`TRACE_REG_AW-1:0]             shadow_sel;
    logic [`TRACE_XLEN-1:0]               shadow_data;
    csr_word_e                            csr_sel;
    logic [`TRACE_XLEN-1:0]               csr_word;
    logic [`TRACE_CNT_W-1:0]              chg_count;

    retire_tracker u_tracker (
        .clk, .rst_n, .update_pc_en, .update_pc, .mprf_wr_en, .mprf_wr_addr,
        .mprf_wr_data, .mstatus_mie_up, .instr_sort, .shadow_sel,
        .class_strb, .last_pc, .last_waddr, .last_wdata, .shadow_data
    );

    for (genvar g = 0; g < `TRACE_NCLASS; g++) begin : g_class
        class_counter u_cnt (
            .clk   (clk),
            .rst_n (rst_n),
            .strb  (class_strb[g]),
            .count (class_count[g*`TRACE_CNT_W +: `TRACE_CNT_W])
        );
    end

    csr_snapshot u_csr (
        .clk, .rst_n, .mstatus_mie, .mstatus_mpie, .mtvec_base, .mtvec_mode,
        .mie_msie, .mie_mtie, .mie_meie, .mip_msip, .mip_mtip, .mip_meip,
        .mepc, .mcause_i, .mcause_ec, .mtval, .csr_sel, .csr_word, .chg_count
    );

    trace_readout u_readout (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .shadow_data,
        .csr_word, .chg_count, .last_pc, .last_waddr, .last_wdata,
        .class_count, .wb_ack, .wb_dat_o, .shadow_sel, .csr_sel
    );

endmodule

/* source/trace_readout.sv */
//--------------------------------------------------------------------
// Wishbone classic read slave over the trace register map
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_readout (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [`TRACE_WB_AW-1:0]                  wb_adr,
    input  logic [`TRACE_XLEN-1:0]                   shadow_data,
    input  logic [`TRACE_XLEN-1:0]                   csr_word,
    input  logic [`TRACE_CNT_W-1:0]                  chg_count,
    input  logic [`TRACE_XLEN-1:0]                   last_pc,
    input  logic [`TRACE_REG_AW-1:0]                 last_waddr,
    input  logic [`TRACE_XLEN-1:0]                   last_wdata,
    input  logic [`TRACE_NCLASS*`TRACE_CNT_W-1:0]    class_count,
    output logic                                     wb_ack,
    output logic [`TRACE_XLEN-1:0]                   wb_dat_o,
    output logic [`TRACE_REG_AW-1:0]                 shadow_sel,
    output trace_arch_pkg::csr_word_e                csr_sel
);
    import trace_arch_pkg::*;
    import trace_mon_pkg::*;

    wb_state_e               state_q;
    logic                    req;
    logic [`TRACE_WB_AW-1:0] cls_off;
    logic [`TRACE_XLEN-1:0]  map_data;

    assign req        = wb_cyc & wb_stb;
    assign shadow_sel = wb_adr[`TRACE_REG_AW-1:0];
    assign csr_sel    = csr_word_e'(wb_adr[2:0]);
    assign cls_off    = wb_adr - `TRACE_MAP_CLASS;

    //----------------------------------------------------------------
    // Address decode
    //----------------------------------------------------------------
    always_comb begin
        map_data = '0;  // Unmapped
        if (wb_adr < `TRACE_MAP_CSR)
            map_data = shadow_data;
        else if (wb_adr < `TRACE_MAP_CHG)
            map_data = csr_word;
        else if (wb_adr == `TRACE_MAP_CHG)
            map_data = chg_count;
        else if (wb_adr == `TRACE_MAP_PC)
            map_data = last_pc;
        else if (wb_adr == `TRACE_MAP_WADDR)
            map_data = {{(`TRACE_XLEN-`TRACE_REG_AW){1'b0}}, last_waddr};
        else if (wb_adr == `TRACE_MAP_WDATA)
            map_data = last_wdata;
        else if (wb_adr >= `TRACE_MAP_CLASS && cls_off < `TRACE_NCLASS)
            map_data = class_count[cls_off*`TRACE_CNT_W +: `TRACE_CNT_W];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= WB_IDLE;
        end else begin
            case (state_q)
                WB_IDLE: if (req) state_q <= WB_ACK;
                default: state_q <= WB_IDLE;    // Single-cycle ack
            endcase
        end
    end

    // Writes get an ack and read back zero
    always_ff @(posedge clk) begin
        if (state_q == WB_IDLE && req)
            wb_dat_o <= wb_we ? '0 : map_data;
    end

    assign wb_ack = (state_q == WB_ACK);

endmodule

/* source/csr_snapshot.sv */
//--------------------------------------------------------------------
// Packs the machine CSR fields into architectural words,
// keeps the previous snapshot and counts snapshot changes
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "trace_params.svh"

module csr_snapshot (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mstatus_mie,
    input  logic                         mstatus_mpie,
    input  logic [`TRACE_XLEN-1:6]       mtvec_base,
    input  logic                         mtvec_mode,
    input  logic                         mie_msie,
    input  logic                         mie_mtie,
    input  logic                         mie_meie,
    input  logic                         mip_msip,
    input  logic                         mip_mtip,
    input  logic                         mip_meip,
    input  logic [`TRACE_XLEN-1:1]       mepc,
    input  logic                         mcause_i,
    input  trace_arch_pkg::exc_code_e    mcause_ec,
    input  logic [`TRACE_XLEN-1:0]       mtval,
    input  trace_arch_pkg::csr_word_e    csr_sel,
    output logic [`TRACE_XLEN-1:0]       csr_word,
    output logic [`TRACE_CNT_W-1:0]      chg_count
);
    import trace_arch_pkg::*;

    localparam int mstatus_mie_pos  = 3;
    localparam int mstatus_mpie_pos = 7;
    localparam int mstatus_mpp_pos  = 11;
    localparam int irq_sw_pos       = 3;
    localparam int irq_tmr_pos      = 7;
    localparam int irq_ext_pos      = 11;

    logic [MTVAL:0][`TRACE_XLEN-1:0] live;
    logic [MTVAL:0][`TRACE_XLEN-1:0] snap_q;

    always_comb begin
        live = '0;
        live[MSTATUS][mstatus_mie_pos]                    = mstatus_mie;
        live[MSTATUS][mstatus_mpie_pos]                   = mstatus_mpie;
        live[MSTATUS][mstatus_mpp_pos+1:mstatus_mpp_pos]  = 2'b11;  // M-mode only
        live[MTVEC]   = {mtvec_base, 5'b0, mtvec_mode};
        live[MIE][irq_sw_pos]  = mie_msie;
        live[MIE][irq_tmr_pos] = mie_mtie;
        live[MIE][irq_ext_pos] = mie_meie;
        live[MIP][irq_sw_pos]  = mip_msip;
        live[MIP][irq_tmr_pos] = mip_mtip;
        live[MIP][irq_ext_pos] = mip_meip;
        live[MEPC]    = {mepc, 1'b0};
        live[MCAUSE]  = {mcause_i, {(`TRACE_XLEN-5){1'b0}}, mcause_ec};
        live[MTVAL]   = mtval;
    end

    //----------------------------------------------------------------
    // Snapshot and change counter
    //----------------------------------------------------------------
    always_ff @(posedge clk) begin
        snap_q <= live;  // Tracks live fields in reset too
        if (!rst_n)
            chg_count <= '0;
        else if (live != snap_q)
            chg_count <= chg_count + 1'b1;
    end

    assign csr_word = (csr_sel <= MTVAL) ? snap_q[csr_sel] : '0;

endmodule

/* source/class_counter.sv */
//--------------------------------------------------------------------
// Saturating retirement counter for one instruction class
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "trace_params.svh"

module class_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     strb,
    output logic [`TRACE_CNT_W-1:0]  count
);

    logic at_max;

    assign at_max = &count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (strb && !at_max) begin
            count <= count + 1'b1;  // Holds at all ones
        end
    end

endmodule

/* source/retire_tracker.sv */
//--------------------------------------------------------------------
// Retire event detection, class strobes, shadow register file
// and the record of the last PC and register write
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "trace_params.svh"

module retire_tracker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        update_pc_en,
    input  logic [`TRACE_XLEN-1:0]      update_pc,
    input  logic                        mprf_wr_en,
    input  logic [`TRACE_REG_AW-1:0]    mprf_wr_addr,
    input  logic [`TRACE_XLEN-1:0]      mprf_wr_data,
    input  logic                        mstatus_mie_up,
    input  trace_mon_pkg::instr_class_e instr_sort,
    input  logic [`TRACE_REG_AW-1:0]    shadow_sel,
    output logic [`TRACE_NCLASS-1:0]    class_strb,
    output logic [`TRACE_XLEN-1:0]      last_pc,
    output logic [`TRACE_REG_AW-1:0]    last_waddr,
    output logic [`TRACE_XLEN-1:0]      last_wdata,
    output logic [`TRACE_XLEN-1:0]      shadow_data
);
    import trace_mon_pkg::*;

    logic                   retire;
    logic                   retire_r;
    instr_class_e           class_r;
    logic [`TRACE_XLEN-1:0] shadow_q [1:`TRACE_NREG-1];

    // IE updates alone are not retirements
    assign retire = update_pc_en | (mprf_wr_en & ~mstatus_mie_up);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_r   <= 1'b0;
            class_r    <= RVI_CAL;
            last_pc    <= '0;
            last_waddr <= '0;
            last_wdata <= '0;
            for (int i = 1; i < `TRACE_NREG; i++) begin
                shadow_q[i] <= '0;
            end
        end else begin
            retire_r <= retire;
            if (retire) begin
                class_r <= instr_sort;
                last_pc <= update_pc;
            end
            if (mprf_wr_en && (mprf_wr_addr != '0)) begin
                shadow_q[mprf_wr_addr] <= mprf_wr_data;
                last_waddr             <= mprf_wr_addr;
                last_wdata             <= mprf_wr_data;
            end
        end
    end

    //----------------------------------------------------------------
    // One-hot class strobe
    //----------------------------------------------------------------
    always_comb begin
        class_strb = '0;
        if (retire_r) begin
            if (class_r > OTHER)
                class_strb[OTHER] = 1'b1;   // Reserved codes
            else
                class_strb[class_r] = 1'b1;
        end
    end

    assign shadow_data = (shadow_sel == '0) ? '0 : shadow_q[shadow_sel];  // x0 hardwired

endmodule

/* source/trace_mon_pkg.sv */
//--------------------------------------------------------------------
// Monitor types: instruction classes and Wishbone slave state
//--------------------------------------------------------------------
package trace_mon_pkg;

    // Codes above OTHER are counted as OTHER
    typedef enum logic [3:0] {
        RVI_CAL   = 4'd0,
        RVI_CTRL  = 4'd1,
        RVI_LS    = 4'd2,
        RVI_OTHER = 4'd3,
        RVC_CAL   = 4'd4,
        RVC_CTRL  = 4'd5,
        RVC_LS    = 4'd6,
        RVC_OTHER = 4'd7,
        RVY_CAL   = 4'd8,
        RVY_LS    = 4'd9,
        OTHER     = 4'd10
    } instr_class_e;

    //----------------------------------------------------------------
    // Wishbone classic read slave
    //----------------------------------------------------------------
    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage

/* source/trace_arch_pkg.sv */
//--------------------------------------------------------------------
// RISC-V architectural types
// mcause exception codes and the index of the traced CSR words
//--------------------------------------------------------------------
package trace_arch_pkg;

    // mcause exception code, low 4 bits
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGN   = 4'd0,
        EXC_INSTR_ACCESS     = 4'd1,
        EXC_ILLEGAL_INSTR    = 4'd2,
        EXC_BREAKPOINT       = 4'd3,
        EXC_LD_MISALIGN      = 4'd4,
        EXC_LD_ACCESS        = 4'd5,
        EXC_ST_MISALIGN      = 4'd6,
        EXC_ST_ACCESS        = 4'd7,
        EXC_ECALL_U          = 4'd8,
        EXC_ECALL_M          = 4'd11
    } exc_code_e;

    //----------------------------------------------------------------
    // Traced machine CSR words, in register-map order
    //----------------------------------------------------------------
    typedef enum logic [2:0] {
        MSTATUS = 3'd0,
        MTVEC   = 3'd1,
        MIE     = 3'd2,
        MIP     = 3'd3,
        MEPC    = 3'd4,
        MCAUSE  = 3'd5,
        MTVAL   = 3'd6
    } csr_word_e;

endpackage

/* source/trace_params.svh */
//--------------------------------------------------------------------
// Widths, counts and register-map word addresses of the trace monitor
//--------------------------------------------------------------------
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

`define TRACE_XLEN          32
`define TRACE_NREG          32
`define TRACE_REG_AW        5
`define TRACE_NCLASS        11
`define TRACE_CNT_W         32
`define TRACE_WB_AW         7

// Register map, word addresses
`define TRACE_MAP_SHADOW    7'h00
`define TRACE_MAP_CSR       7'h20
`define TRACE_MAP_CHG       7'h27
`define TRACE_MAP_PC        7'h28
`define TRACE_MAP_WADDR     7'h29
`define TRACE_MAP_WDATA     7'h2A
`define TRACE_MAP_CLASS     7'h30

`endif
